//--- verilog.f
+incdir+design
design/fp_cvt_pkg.sv
design/fp_cvt_unpack.sv
design/fp_cvt_buffer.sv
design/fp_cvt_round.sv
design/fp_cvt_top.sv
verif/tb_clock.sv
verif/tb_fp_cvt.sv

//--- Makefile
# Verilator simulation of the FP conversion unit

VERILATOR ?= verilator
TOP       ?= tb_fp_cvt
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

//--- verif/tb_fp_cvt.sv
/*
 * FP conversion unit testbench
 * Credit-driven stimulus, reference model and assertion checks
 */
`timescale 1ns/1ps
`include "fp_cvt_cfg.svh"

module tb_fp_cvt import fp_cvt_pkg::*; ();

  localparam int WAIT_LIMIT = 2000;

  logic     clk;
  logic     reset_n;
  logic     req_valid;
  cvt_req_t req;
  logic     req_credit;
  logic     rsp_valid;
  cvt_rsp_t rsp;
  logic     rsp_credit;

  cvt_rsp_t exp_q[$];
  cvt_rsp_t exp_now;
  logic     exp_avail;
  int       errors;
  int       sent;
  int       returned;
  int       rsp_count;
  int       ds_returned;
  int       tests_pass;
  int       tests_fail;
  bit       hold_credits;

  tb_clock clk_gen (.clk(clk));

  fp_cvt_top dut0 (
    .clk        (clk),
    .reset_n    (reset_n),
    .req_valid  (req_valid),
    .req        (req),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .rsp_credit (rsp_credit)
  );

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic cvt_rsp_t ref_conv(input cvt_op_e op, input logic [2:0] rm,
                                        input logic [31:0] operand);
    cvt_rsp_t    r;
    logic        neg;
    logic        is_w;
    logic        up;
    logic        lost;
    logic [63:0] mag;
    logic [63:0] keep;
    logic [63:0] rem;
    logic [63:0] half;
    logic [63:0] sig;
    logic [31:0] sat_p;
    logic [31:0] sat_n;
    int          p;
    int          sh;
    int          e;
    r = '0;
    up = 1'b0;
    lost = 1'b0;
    if ((op == cvt_s_w) || (op == cvt_s_wu)) begin
      neg = (op == cvt_s_w) && operand[31];
      mag = {32'd0, neg ? (~operand + 32'd1) : operand};
      if (mag == 64'd0) begin
        return r;
      end
      p = 0;
      for (int i = 0; i < 32; i++) begin
        if (mag[i]) begin
          p = i;
        end
      end
      if (p <= 23) begin
        keep = mag << (23 - p);
      end else begin
        sh   = p - 23;
        keep = mag >> sh;
        rem  = mag & ((64'd1 << sh) - 64'd1);
        half = 64'd1 << (sh - 1);
        lost = (rem != 64'd0);
        case (rm)
          3'd0:    up = (rem > half) || ((rem == half) && keep[0]);
          3'd2:    up = neg && lost;
          3'd3:    up = !neg && lost;
          3'd4:    up = (rem >= half);
          default: up = 1'b0;
        endcase
      end
      keep = keep + {63'd0, up};
      // Carry past the hidden bit bumps the exponent
      if (keep[24]) begin
        keep = keep >> 1;
        p++;
      end
      r.result   = {neg, 8'(p + `CVT_BIAS), keep[22:0]};
      r.flags.nx = lost;
      return r;
    end
    neg   = operand[31];
    is_w  = (op == cvt_w_s);
    e     = int'(operand[30:23]) - `CVT_BIAS;
    sig   = {40'd0, 1'b1, operand[22:0]};
    sat_p = is_w ? 32'h7FFF_FFFF : 32'hFFFF_FFFF;
    sat_n = is_w ? 32'h8000_0000 : 32'h0000_0000;
    if ((operand[30:23] == 8'hFF) && (operand[22:0] != 23'd0)) begin
      r.result   = sat_p;
      r.flags.nv = 1'b1;
    end else if (operand[30:23] == 8'hFF) begin
      r.result   = neg ? sat_n : sat_p;
      r.flags.nv = 1'b1;
    end else if (operand[30:0] == 31'd0) begin
      r.result = 32'd0;
    end else if (e < 0) begin
      r.flags.nx = 1'b1;
    end else if (is_w && ((e > 31) || ((e == 31) && !(neg && (operand[22:0] == 23'd0))))) begin
      r.result   = neg ? sat_n : sat_p;
      r.flags.nv = 1'b1;
    end else if (!is_w && neg) begin
      r.flags.nv = 1'b1;
    end else if (!is_w && (e > 31)) begin
      r.result   = sat_p;
      r.flags.nv = 1'b1;
    end else begin
      if (e >= 23) begin
        mag = sig << (e - 23);
      end else begin
        mag  = sig >> (23 - e);
        lost = ((sig & ((64'd1 << (23 - e)) - 64'd1)) != 64'd0);
      end
      r.result   = neg ? (~mag[31:0] + 32'd1) : mag[31:0];
      r.flags.nx = lost;
    end
    return r;
  endfunction

  // --------------------------------------------------
  // Scoreboard and credit bookkeeping
  // --------------------------------------------------
  // Head of the queue as seen by the next rising edge
  always @(negedge clk) begin
    exp_avail = (exp_q.size() != 0);
    exp_now   = exp_avail ? exp_q[0] : '0;
  end

  always @(posedge clk) begin
    if (reset_n && rsp_valid) begin
      rsp_count++;
      if (exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
    end
    if (reset_n && req_credit) begin
      returned++;
    end
  end

  // Downstream returns credits with random gaps and none while held
  initial begin
    rsp_credit = 1'b0;
    @(posedge reset_n);
    forever begin
      @(posedge clk);
      #1;
      rsp_credit = 1'b0;
      if (!hold_credits && (rsp_count > ds_returned) && ($urandom_range(3, 0) != 0)) begin
        rsp_credit = 1'b1;
        ds_returned++;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    (!reset_n || $rose(reset_n)) |-> (!rsp_valid && !req_credit))
    else begin
      $display("rsp_valid or req_credit active around reset");
      errors++;
    end

  a_rsp_expected: assert property (@(posedge clk) disable iff (!reset_n)
    rsp_valid |-> exp_avail)
    else begin
      $display("response arrived with no request outstanding");
      errors++;
    end

  a_rsp_value: assert property (@(posedge clk) disable iff (!reset_n)
    (rsp_valid && exp_avail) |-> (rsp == exp_now))
    else begin
      $display("CHECK FAILED rsp.result/flags expected %h/%h got %h/%h",
               exp_now.result, exp_now.flags, $sampled(rsp.result), $sampled(rsp.flags));
      errors++;
    end

  a_rsp_credit_use: assert property (@(posedge clk) disable iff (!reset_n)
    rsp_valid |-> (rsp_count < `CVT_RSP_CREDITS + ds_returned))
    else begin
      $display("response sent without a downstream credit");
      errors++;
    end

  a_req_credit_bound: assert property (@(posedge clk) disable iff (!reset_n)
    req_credit |-> (`CVT_BUF_DEPTH - sent + returned < `CVT_BUF_DEPTH))
    else begin
      $display("request credit returned beyond the buffer depth");
      errors++;
    end

  // --------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------
  task automatic send_req(input cvt_op_e op, input logic [2:0] rm, input logic [31:0] operand);
    int waited;
    waited = 0;
    while (`CVT_BUF_DEPTH - sent + returned == 0) begin
      req_valid = 1'b0;
      @(posedge clk);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timed out waiting for a request credit");
        errors++;
        break;
      end
    end
    req_valid   = 1'b1;
    req.op      = op;
    req.rm      = round_mode_e'(rm);
    req.operand = operand;
    exp_q.push_back(ref_conv(op, rm, operand));
    sent++;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  // All responses seen and every downstream credit handed back
  task automatic drain();
    int waited;
    waited = 0;
    while ((exp_q.size() != 0) || (ds_returned != rsp_count)) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timed out waiting for %0d outstanding responses and their credits",
                 exp_q.size());
        errors++;
        break;
      end
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    drain();
    if (errors == err_before) begin
      tests_pass++;
      $display("test %s passed", name);
    end else begin
      tests_fail++;
      $display("test %s failed with %0d errors", name, errors - err_before);
    end
  endtask

  function automatic logic [31:0] rand_float(input logic sign, input int exp_max);
    logic [7:0] ex;
    ex = 8'(`CVT_BIAS + $urandom_range(exp_max, 0));
    return {sign, ex, 23'($urandom)};
  endfunction

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    int         e0;
    logic [31:0] exact_vals[5];
    void'($urandom(32'h84c9));
    reset_n      = 1'b0;
    req_valid    = 1'b0;
    req          = '0;
    hold_credits = 1'b0;
    exact_vals   = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h00FF_FFFF, 32'h8000_0000};
    e0 = errors;
    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;

    repeat (4) @(posedge clk);
    #1;
    end_test("reset_state", e0);

    e0 = errors;
    for (int m = 0; m < 5; m++) begin
      foreach (exact_vals[i]) begin
        send_req(cvt_s_w, 3'(m), exact_vals[i]);
      end
      send_req(cvt_s_wu, 3'(m), 32'h00FF_FFFF);
    end
    end_test("int_to_float_exact", e0);

    e0 = errors;
    send_req(cvt_s_w, 3'd0, 32'h01FF_FFFF);
    send_req(cvt_s_w, 3'd0, 32'h0100_0003);
    send_req(cvt_s_w, 3'd3, 32'h0100_0001);
    send_req(cvt_s_w, 3'd2, 32'hFEFF_FFFD);
    send_req(cvt_s_w, 3'd3, 32'hFEFF_FFFD);
    send_req(cvt_s_w, 3'd4, 32'h0100_0001);
    send_req(cvt_s_wu, 3'd0, 32'hFFFF_FFFF);
    for (int m = 0; m < 8; m++) begin
      for (int i = 0; i < 6; i++) begin
        send_req(($urandom_range(1, 0) != 0) ? cvt_s_w : cvt_s_wu, 3'(m), $urandom);
      end
    end
    end_test("int_to_float_inexact", e0);

    e0 = errors;
    for (int i = 0; i < 30; i++) begin
      send_req(cvt_w_s, 3'($urandom_range(7, 0)), rand_float(1'($urandom), 30));
      send_req(cvt_wu_s, 3'd0, rand_float(1'b0, 31));
    end
    send_req(cvt_w_s, 3'd0, 32'h3F00_0000);
    send_req(cvt_wu_s, 3'd0, 32'hBE80_0000);
    send_req(cvt_w_s, 3'd0, 32'h0000_0001);
    send_req(cvt_w_s, 3'd0, 32'hCF00_0000);
    send_req(cvt_w_s, 3'd0, 32'hBFC0_0000);
    end_test("float_to_int_normal", e0);

    e0 = errors;
    for (int o = 0; o < 2; o++) begin
      send_req(cvt_op_e'(o), 3'd0, 32'h7FC0_0000);
      send_req(cvt_op_e'(o), 3'd0, 32'hFFFF_FFFF);
      send_req(cvt_op_e'(o), 3'd0, 32'h7F80_0000);
      send_req(cvt_op_e'(o), 3'd0, 32'hFF80_0000);
      send_req(cvt_op_e'(o), 3'd0, 32'h4F80_0000);
      send_req(cvt_op_e'(o), 3'd0, 32'hCF80_0000);
      send_req(cvt_op_e'(o), 3'd0, 32'h8000_0000);
    end
    send_req(cvt_w_s, 3'd0, 32'h4F00_0000);
    send_req(cvt_w_s, 3'd0, 32'hCF00_0001);
    send_req(cvt_wu_s, 3'd0, 32'hBF80_0000);
    send_req(cvt_wu_s, 3'd0, 32'hC2C8_0000);
    end_test("float_to_int_special", e0);

    e0 = errors;
    hold_credits = 1'b1;
    // Two responses plus a full buffer fit before the upstream stalls
    repeat (`CVT_BUF_DEPTH + `CVT_RSP_CREDITS) begin
      send_req(cvt_op_e'($urandom_range(3, 0)), 3'($urandom_range(7, 0)), $urandom);
    end
    repeat ($urandom_range(20, 5)) @(posedge clk);
    #1;
    hold_credits = 1'b0;
    for (int i = 0; i < 60; i++) begin
      send_req(cvt_op_e'($urandom_range(3, 0)), 3'($urandom_range(7, 0)), $urandom);
      if ($urandom_range(9, 0) == 0) begin
        hold_credits = 1'b1;
        repeat ($urandom_range(12, 1)) @(posedge clk);
        #1;
        hold_credits = 1'b0;
      end
    end
    end_test("flow_control", e0);

    if ((exp_q.size() != 0) || (rsp_count != sent)) begin
      $display("request and response counts differ, %0d sent, %0d received", sent, rsp_count);
      errors++;
    end
    $display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, errors);
    if ((errors == 0) && (tests_fail == 0)) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Overall limit on simulated time
  initial begin
    #2ms;
    $display("simulation did not finish within the time limit");
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- verif/tb_clock.sv
/*
 * Testbench clock generator
 * Free-running clock with an 8 ns period
 */
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  localparam realtime HALF_PERIOD = 4.0;

  initial begin
    clk = 1'b0;
  end

  always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- design/fp_cvt_top.sv
/*
 * FP conversion unit top level
 * Producer, intermediate FIFO and consumer with credit flow control
 */
`timescale 1ns/1ps

module fp_cvt_top import fp_cvt_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     req_valid,
  input  cvt_req_t req,
  output logic     req_credit,
  output logic     rsp_valid,
  output cvt_rsp_t rsp,
  input  logic     rsp_credit
);

  // Producer to FIFO
  logic     mid_valid;
  cvt_mid_t mid;

  // FIFO to consumer
  logic     head_valid;
  cvt_mid_t head;
  logic     pop;

  fp_cvt_unpack u_unpack (
    .clk       (clk),
    .reset_n   (reset_n),
    .req_valid (req_valid),
    .req       (req),
    .mid_valid (mid_valid),
    .mid       (mid)
  );

  fp_cvt_buffer u_buffer (
    .clk        (clk),
    .reset_n    (reset_n),
    .push       (mid_valid),
    .push_data  (mid),
    .head_valid (head_valid),
    .head       (head),
    .pop        (pop),
    .req_credit (req_credit)
  );

  fp_cvt_round u_round (
    .clk        (clk),
    .reset_n    (reset_n),
    .head_valid (head_valid),
    .head       (head),
    .pop        (pop),
    .rsp_credit (rsp_credit),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp)
  );

endmodule

//--- design/fp_cvt_round.sv
/*
 * FP conversion consumer stage
 * Rounds and packs integer-to-float results and sends responses under credits
 */
`timescale 1ns/1ps
`include "fp_cvt_cfg.svh"

module fp_cvt_round import fp_cvt_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     head_valid,
  input  cvt_mid_t head,
  output logic     pop,
  input  logic     rsp_credit,
  output logic     rsp_valid,
  output cvt_rsp_t rsp
);

  localparam logic [`CVT_CREDIT_W-1:0] CREDITS_INIT = `CVT_RSP_CREDITS;

  logic [`CVT_CREDIT_W-1:0] credits;
  logic                     any_lost;
  logic                     round_up;
  logic [30:0]              mag_rounded;
  cvt_rsp_t                 rsp_d;

  // Accept the head only while a downstream credit is held
  assign pop = head_valid && (credits != '0);

  // --------------------------------------------------
  // Rounding decision
  // --------------------------------------------------
  assign any_lost = head.guard | head.round | head.sticky;

  always_comb begin
    case (head.rm)
      rm_rne:  round_up = head.guard && (head.round || head.sticky || head.man[0]);
      rm_rtz:  round_up = 1'b0;
      rm_rdn:  round_up = head.sign && any_lost;
      rm_rup:  round_up = !head.sign && any_lost;
      rm_rmm:  round_up = head.guard;
      default: round_up = 1'b0;
    endcase
  end

  // A full mantissa carries straight into the exponent field
  assign mag_rounded = {head.exp, head.man} + {30'd0, round_up};

  always_comb begin
    if (head.to_float) begin
      rsp_d.result   = {head.sign, mag_rounded};
      rsp_d.flags.nv = 1'b0;
      rsp_d.flags.nx = any_lost;
    end else begin
      rsp_d.result = head.int_value;
      rsp_d.flags  = head.flags;
    end
  end

  // --------------------------------------------------
  // Credits and response register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      credits   <= CREDITS_INIT;
      rsp_valid <= 1'b0;
    end else begin
      case ({pop, rsp_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
      rsp_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      rsp <= rsp_d;
    end
  end

  // Downstream never returns more credits than it was given
  a_credit_bound: assert property (@(posedge clk) disable iff (!reset_n)
    credits <= CREDITS_INIT);

endmodule

//--- design/fp_cvt_buffer.sv
/*
 * FP conversion intermediate FIFO
 * Returns one request credit upstream for every entry popped
 */
`timescale 1ns/1ps
`include "fp_cvt_cfg.svh"

module fp_cvt_buffer import fp_cvt_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     push,
  input  cvt_mid_t push_data,
  output logic     head_valid,
  output cvt_mid_t head,
  input  logic     pop,
  output logic     req_credit
);

  localparam int PTR_W = $clog2(`CVT_BUF_DEPTH);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(`CVT_BUF_DEPTH - 1);
  localparam logic [`CVT_CREDIT_W-1:0] DEPTH = `CVT_BUF_DEPTH;

  cvt_mid_t                 mem [`CVT_BUF_DEPTH];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [`CVT_CREDIT_W-1:0] count;
  logic                     full;

  assign full       = (count == DEPTH);
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // --------------------------------------------------
  // Pointers, occupancy and credit return
  // --------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      req_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit pulse per freed slot
      req_credit <= pop;
    end
  end

  // Upstream credits must keep pushes away from a full FIFO
  a_no_push_full: assert property (@(posedge clk) disable iff (!reset_n)
    push |-> !full);

  // Consumer only pops a valid head
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
    pop |-> head_valid);

endmodule

//--- design/fp_cvt_unpack.sv
/*
 * FP conversion producer stage
 * Finishes float-to-integer, normalizes integers for the rounding stage
 */
`timescale 1ns/1ps
`include "fp_cvt_cfg.svh"

module fp_cvt_unpack import fp_cvt_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     req_valid,
  input  cvt_req_t req,
  output logic     mid_valid,
  output cvt_mid_t mid
);

  localparam logic signed [9:0] BIAS = `CVT_BIAS;
  localparam logic [`CVT_EXP_W-1:0] EXP_TOP = `CVT_BIAS + 31;

  // Float operand fields
  logic                  f_sign;
  logic [`CVT_EXP_W-1:0] f_exp;
  logic [`CVT_MAN_W-1:0] f_man;
  logic                  f_nan;
  logic                  f_inf;
  logic                  f_zero;
  logic signed [9:0]     f_unb;
  logic [4:0]            f_shamt;
  logic [63:0]           f_fix;
  logic [31:0]           f_mag;
  logic                  f_lost;
  logic [31:0]           sat_pos;
  logic [31:0]           sat_neg;
  logic                  is_w;

  // Integer operand
  logic        i_neg;
  logic [31:0] i_mag;
  logic [4:0]  i_lz;
  logic [31:0] i_norm;

  logic     to_float;
  cvt_mid_t mid_d;

  // Priority encoder where the highest set bit wins
  function automatic logic [4:0] count_lz(input logic [31:0] value);
    logic [4:0] lz;
    lz = 5'd0;
    for (int i = 0; i < 32; i++) begin
      if (value[i]) begin
        lz = 5'(31 - i);
      end
    end
    return lz;
  endfunction

  assign to_float = (req.op == cvt_s_w) || (req.op == cvt_s_wu);
  assign is_w     = (req.op == cvt_w_s);

  // --------------------------------------------------
  // Float to integer
  // --------------------------------------------------
  assign f_sign = req.operand[31];
  assign f_exp  = req.operand[30:23];
  assign f_man  = req.operand[22:0];
  assign f_nan  = (f_exp == '1) && (f_man != '0);
  assign f_inf  = (f_exp == '1) && (f_man == '0);
  assign f_zero = (req.operand[30:0] == '0);
  assign f_unb  = $signed({2'b00, f_exp}) - BIAS;

  // Leading one sits at bit 63 so the integer part lands in the upper word
  assign f_shamt = 5'd31 - f_unb[4:0];
  assign f_fix   = {1'b1, f_man, 40'd0} >> f_shamt;
  assign f_mag   = f_fix[63:32];
  assign f_lost  = |f_fix[31:0];

  assign sat_pos = is_w ? 32'h7FFF_FFFF : 32'hFFFF_FFFF;
  assign sat_neg = is_w ? 32'h8000_0000 : 32'h0000_0000;

  // --------------------------------------------------
  // Integer to float
  // --------------------------------------------------
  assign i_neg  = (req.op == cvt_s_w) && req.operand[31];
  assign i_mag  = i_neg ? -req.operand : req.operand;
  assign i_lz   = count_lz(i_mag);
  assign i_norm = i_mag << i_lz;

  always_comb begin
    mid_d          = '0;
    mid_d.to_float = to_float;
    mid_d.rm       = req.rm;
    if (to_float) begin
      // Zero input leaves everything clear and packs as +0.0
      if (i_mag != '0) begin
        mid_d.sign   = i_neg;
        mid_d.exp    = EXP_TOP - {3'b000, i_lz};
        mid_d.man    = i_norm[30:8];
        mid_d.guard  = i_norm[7];
        mid_d.round  = i_norm[6];
        mid_d.sticky = |i_norm[5:0];
      end
    end else if (f_nan) begin
      mid_d.int_value = sat_pos;
      mid_d.flags.nv  = 1'b1;
    end else if (f_inf) begin
      mid_d.int_value = f_sign ? sat_neg : sat_pos;
      mid_d.flags.nv  = 1'b1;
    end else if (f_zero) begin
      mid_d.int_value = '0;
    end else if (f_unb < 0) begin
      // Magnitude below one truncates to zero
      mid_d.flags.nx = 1'b1;
    end else if (is_w) begin
      // Exactly -2^31 is still representable
      if ((f_unb > 30) && !(f_sign && (f_unb == 31) && (f_man == '0))) begin
        mid_d.int_value = f_sign ? sat_neg : sat_pos;
        mid_d.flags.nv  = 1'b1;
      end else begin
        mid_d.int_value = f_sign ? -f_mag : f_mag;
        mid_d.flags.nx  = f_lost;
      end
    end else if (f_sign) begin
      mid_d.flags.nv = 1'b1;
    end else if (f_unb > 31) begin
      mid_d.int_value = sat_pos;
      mid_d.flags.nv  = 1'b1;
    end else begin
      mid_d.int_value = f_mag;
      mid_d.flags.nx  = f_lost;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mid_valid <= 1'b0;
    end else begin
      mid_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      mid <= mid_d;
    end
  end

  a_mid_valid_known: assert property (@(posedge clk) disable iff (!reset_n)
    !$isunknown(mid_valid));

endmodule

//--- design/fp_cvt_pkg.sv
/*
 * FP conversion unit types
 * Operation and rounding enums plus the request, pipeline and response structs
 */
`include "fp_cvt_cfg.svh"

package fp_cvt_pkg;

  // Conversion operations
  typedef enum logic [1:0] {
    cvt_w_s  = 2'd0,
    cvt_wu_s = 2'd1,
    cvt_s_w  = 2'd2,
    cvt_s_wu = 2'd3
  } cvt_op_e;

  // IEEE rounding modes where codes 5 to 7 behave as rtz
  typedef enum logic [2:0] {
    rm_rne = 3'd0,
    rm_rtz = 3'd1,
    rm_rdn = 3'd2,
    rm_rup = 3'd3,
    rm_rmm = 3'd4
  } round_mode_e;

  typedef struct packed {
    logic nv;
    logic nx;
  } cvt_flags_t;

  // Operand holds an integer or a float depending on op
  typedef struct packed {
    cvt_op_e     op;
    round_mode_e rm;
    logic [31:0] operand;
  } cvt_req_t;

  // Producer to consumer record
  typedef struct packed {
    logic                  to_float;
    round_mode_e           rm;
    logic                  sign;
    logic [`CVT_EXP_W-1:0] exp;
    logic [`CVT_MAN_W-1:0] man;
    logic                  guard;
    logic                  round;
    logic                  sticky;
    logic [31:0]           int_value;
    cvt_flags_t            flags;
  } cvt_mid_t;

  typedef struct packed {
    logic [31:0] result;
    cvt_flags_t  flags;
  } cvt_rsp_t;

endpackage

//--- design/fp_cvt_cfg.svh
/*
 * FP conversion unit configuration
 * Buffer depth, credit counts and single-precision format constants
 */
`ifndef FP_CVT_CFG_SVH
`define FP_CVT_CFG_SVH

// --------------------------------------------------
// Flow control
// --------------------------------------------------

// Intermediate FIFO entries and upstream credits after reset
`define CVT_BUF_DEPTH 4

// Downstream credits held after reset
`define CVT_RSP_CREDITS 2

// Width of credit and occupancy counters
`define CVT_CREDIT_W 3

// --------------------------------------------------
// Single-precision format
// --------------------------------------------------
`define CVT_BIAS 127
`define CVT_EXP_W 8
`define CVT_MAN_W 23

`endif
